// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

typedef logic [31:0] word_t;
typedef logic [4:0]  reg_addr_t;

localparam int REG_NUM     = 32;
localparam int QUEUE_WORDS = 4;
localparam int QUEUE_PTR_W = $clog2(QUEUE_WORDS);
localparam int QUEUE_CNT_W = $clog2(QUEUE_WORDS + 1);

// major opcodes
localparam logic [5:0] OPC_SPECIAL = 6'b000000;
localparam logic [5:0] OPC_ADDIU   = 6'b001001;
localparam logic [5:0] OPC_SLTI    = 6'b001010;
localparam logic [5:0] OPC_ANDI    = 6'b001100;
localparam logic [5:0] OPC_ORI     = 6'b001101;
localparam logic [5:0] OPC_XORI    = 6'b001110;
localparam logic [5:0] OPC_LUI     = 6'b001111;

// function field of SPECIAL
localparam logic [5:0] FN_SLL  = 6'b000000;
localparam logic [5:0] FN_SRL  = 6'b000010;
localparam logic [5:0] FN_ADDU = 6'b100001;
localparam logic [5:0] FN_SUBU = 6'b100011;
localparam logic [5:0] FN_AND  = 6'b100100;
localparam logic [5:0] FN_OR   = 6'b100101;
localparam logic [5:0] FN_XOR  = 6'b100110;
localparam logic [5:0] FN_NOR  = 6'b100111;
localparam logic [5:0] FN_SLT  = 6'b101010;
localparam logic [5:0] FN_SLTU = 6'b101011;

// OP_NONE must stay zero, a cleared stage is a bubble
typedef enum logic [4:0] {
	OP_NONE, OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT, OP_SLTU,
	OP_SLL, OP_SRL, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_LUI
} alu_op_t;

typedef struct packed {
	word_t pc;
	word_t inst1;
	word_t inst2;
} inst_pair_t;

typedef struct packed {
	word_t inst;
	word_t pc;
} queue_word_t;

typedef struct packed {
	logic      we;
	reg_addr_t waddr;
	word_t     wdata;
} reg_wr_t;

typedef struct packed {
	logic      valid;
	word_t     pc;
	alu_op_t   op;
	reg_addr_t waddr;
	logic      we;
	reg_addr_t raddr1;
	reg_addr_t raddr2;
	logic      reg1_used;
	logic      reg2_used;
	word_t     opr1;
	word_t     opr2;
} decoded_t;

typedef struct packed {
	logic      valid;
	word_t     pc;
	reg_addr_t waddr;
	word_t     wdata;
} commit_t;

// index 0 is slot a, index 1 is slot b
typedef decoded_t [1:0] decoded_pair_t;
typedef commit_t [1:0] commit_pair_t;

function automatic commit_t to_commit(reg_wr_t wr, word_t pc);
	commit_t c;
	c.valid = wr.we;
	c.pc    = pc;
	c.waddr = wr.waddr;
	c.wdata = wr.wdata;
	return c;
endfunction

function automatic reg_wr_t commit_to_wr(commit_t c);
	reg_wr_t wr;
	wr.we    = c.valid;
	wr.waddr = c.waddr;
	wr.wdata = c.wdata;
	return wr;
endfunction

endpackage

// ==== verilog/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  payload_t in_data,
	output payload_t out_data
);

// all zeros reads as an invalid entry
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n)
		out_data <= '0;
	else
		out_data <= in_data;
end

endmodule

// ==== verilog/inst_queue.sv ====
`timescale 1ns/1ps

module inst_queue import cpu_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  inst_pair_t  inst_pair,
	input  logic        inst_valid,
	output logic        inst_ready,
	output queue_word_t head_a,
	output queue_word_t head_b,
	output logic        head_a_valid,
	output logic        head_b_valid,
	input  logic        inst2_taken
);

queue_word_t buf_q [QUEUE_WORDS];
logic [QUEUE_PTR_W-1:0] head_q, tail_q;
logic [QUEUE_CNT_W-1:0] count_q;
logic [QUEUE_CNT_W-1:0] push_cnt, pop_cnt;
logic push;

// a pair needs two free words
assign inst_ready = count_q <= QUEUE_CNT_W'(QUEUE_WORDS - 2);
assign push       = inst_valid && inst_ready;

assign head_a_valid = count_q != '0;
assign head_b_valid = count_q > QUEUE_CNT_W'(1);
assign head_a       = buf_q[head_q];
assign head_b       = buf_q[head_q + QUEUE_PTR_W'(1)];

// slot a issues whenever it holds a word
assign pop_cnt  = QUEUE_CNT_W'(head_a_valid) + QUEUE_CNT_W'(inst2_taken);
assign push_cnt = push ? QUEUE_CNT_W'(2) : '0;

always_ff @(posedge clk) begin
	if (push) begin
		buf_q[tail_q].inst <= inst_pair.inst1;
		buf_q[tail_q].pc   <= inst_pair.pc;
		buf_q[tail_q + QUEUE_PTR_W'(1)].inst <= inst_pair.inst2;
		buf_q[tail_q + QUEUE_PTR_W'(1)].pc   <= inst_pair.pc + 32'd4;
	end
end

// pointers wrap naturally since depth is a power of two
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		head_q  <= '0;
		tail_q  <= '0;
		count_q <= '0;
	end else begin
		if (push)
			tail_q <= tail_q + QUEUE_PTR_W'(2);
		head_q  <= head_q + pop_cnt[QUEUE_PTR_W-1:0];
		count_q <= count_q + push_cnt - pop_cnt;
	end
end

// occupancy never leaves the range of the buffer
assert property (@(posedge clk) disable iff (!rst_n)
	count_q <= QUEUE_CNT_W'(QUEUE_WORDS));

// pairing logic only takes b when both head words are present
assert property (@(posedge clk) disable iff (!rst_n)
	inst2_taken |-> head_a_valid && head_b_valid);

endmodule

// ==== verilog/regs.sv ====
`timescale 1ns/1ps

module regs import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_wr_t   wr1,
	input  reg_wr_t   wr2,
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	input  reg_addr_t raddr3,
	input  reg_addr_t raddr4,
	output word_t     rdata1,
	output word_t     rdata2,
	output word_t     rdata3,
	output word_t     rdata4
);

word_t regs_q [REG_NUM];

// wr2 is the younger write and lands last
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		for (int i = 0; i < REG_NUM; i++)
			regs_q[i] <= '0;
	end else begin
		if (wr1.we && wr1.waddr != '0)
			regs_q[wr1.waddr] <= wr1.wdata;
		if (wr2.we && wr2.waddr != '0)
			regs_q[wr2.waddr] <= wr2.wdata;
	end
end

function automatic word_t read_port(reg_addr_t addr);
	if (addr == '0)
		return '0;
	if (wr2.we && wr2.waddr == addr)
		return wr2.wdata;
	if (wr1.we && wr1.waddr == addr)
		return wr1.wdata;
	return regs_q[addr];
endfunction

always_comb begin
	rdata1 = read_port(raddr1);
	rdata2 = read_port(raddr2);
	rdata3 = read_port(raddr3);
	rdata4 = read_port(raddr4);
end

endmodule

// ==== verilog/cpu_id.sv ====
`timescale 1ns/1ps

module cpu_id import cpu_pkg::*; (
	input  word_t     inst,
	input  word_t     pc,
	input  logic      inst_valid,
	input  word_t     rdata1,
	input  word_t     rdata2,
	input  reg_wr_t   ex_wr_a,
	input  reg_wr_t   ex_wr_b,
	input  reg_wr_t   wb_wr_a,
	input  reg_wr_t   wb_wr_b,
	output reg_addr_t raddr1,
	output reg_addr_t raddr2,
	output decoded_t  decoded
);

logic [5:0] opcode, funct;
reg_addr_t  rs, rt, rd, dest;
logic [4:0] shamt;
alu_op_t    op;
word_t      imm;
logic       use_rs, use_rt, use_shamt, use_imm;

assign opcode = inst[31:26];
assign rs     = inst[25:21];
assign rt     = inst[20:16];
assign rd     = inst[15:11];
assign shamt  = inst[10:6];
assign funct  = inst[5:0];
assign raddr1 = rs;
assign raddr2 = rt;

// youngest producer first, b is younger than a
function automatic word_t forward(reg_addr_t addr, word_t rdata);
	if (ex_wr_b.we && ex_wr_b.waddr == addr)
		return ex_wr_b.wdata;
	if (ex_wr_a.we && ex_wr_a.waddr == addr)
		return ex_wr_a.wdata;
	if (wb_wr_b.we && wb_wr_b.waddr == addr)
		return wb_wr_b.wdata;
	if (wb_wr_a.we && wb_wr_a.waddr == addr)
		return wb_wr_a.wdata;
	return rdata;
endfunction

always_comb begin
	op        = OP_NONE;
	dest      = rt;
	imm       = '0;
	use_rs    = 1'b1;
	use_rt    = 1'b0;
	use_shamt = 1'b0;
	use_imm   = 1'b1;
	case (opcode)
		OPC_SPECIAL: begin
			dest    = rd;
			use_rt  = 1'b1;
			use_imm = 1'b0;
			case (funct)
				FN_ADDU: op = OP_ADDU;
				FN_SUBU: op = OP_SUBU;
				FN_AND:  op = OP_AND;
				FN_OR:   op = OP_OR;
				FN_XOR:  op = OP_XOR;
				FN_NOR:  op = OP_NOR;
				FN_SLT:  op = OP_SLT;
				FN_SLTU: op = OP_SLTU;
				FN_SLL:  op = OP_SLL;
				FN_SRL:  op = OP_SRL;
				default: op = OP_NONE;
			endcase
			// shift amount comes from the word itself
			if (op == OP_SLL || op == OP_SRL) begin
				use_rs    = 1'b0;
				use_shamt = 1'b1;
			end
		end
		OPC_ADDIU: begin
			op  = OP_ADDIU;
			imm = {{16{inst[15]}}, inst[15:0]};
		end
		OPC_SLTI: begin
			op  = OP_SLTI;
			imm = {{16{inst[15]}}, inst[15:0]};
		end
		OPC_ANDI: begin
			op  = OP_ANDI;
			imm = {16'b0, inst[15:0]};
		end
		OPC_ORI: begin
			op  = OP_ORI;
			imm = {16'b0, inst[15:0]};
		end
		OPC_XORI: begin
			op  = OP_XORI;
			imm = {16'b0, inst[15:0]};
		end
		OPC_LUI: begin
			op     = OP_LUI;
			use_rs = 1'b0;
			imm    = {inst[15:0], 16'b0};
		end
		default: op = OP_NONE;
	endcase
	// unknown words and r0 targets become bubbles
	if (op == OP_NONE || dest == '0) begin
		op     = OP_NONE;
		use_rs = 1'b0;
		use_rt = 1'b0;
	end
end

always_comb begin
	decoded.valid     = inst_valid;
	decoded.pc        = pc;
	decoded.op        = op;
	decoded.waddr     = dest;
	decoded.we        = op != OP_NONE;
	decoded.raddr1    = rs;
	decoded.raddr2    = rt;
	decoded.reg1_used = use_rs;
	decoded.reg2_used = use_rt;
	decoded.opr1      = use_shamt ? {27'b0, shamt} : forward(rs, rdata1);
	decoded.opr2      = use_imm ? imm : forward(rt, rdata2);
end

endmodule

// ==== verilog/superscalar_ctrl.sv ====
`timescale 1ns/1ps

module superscalar_ctrl import cpu_pkg::*; (
	input  decoded_t decoded_a,
	input  decoded_t decoded_b,
	output logic     inst2_taken
);

logic hazard_rs, hazard_rt;
logic a_real;

// b would need a's result in the same cycle
assign hazard_rs = decoded_b.reg1_used && decoded_b.raddr1 == decoded_a.waddr;
assign hazard_rt = decoded_b.reg2_used && decoded_b.raddr2 == decoded_a.waddr;

// bubbles in slot a never pair
assign a_real = decoded_a.op != OP_NONE;

assign inst2_taken = decoded_a.valid && decoded_b.valid && a_real
	&& !(decoded_a.we && (hazard_rs || hazard_rt));

always_comb begin
	assert (!decoded_b.valid || decoded_a.valid)
	else $error("slot b holds a word while slot a is empty");
end

endmodule

// ==== verilog/cpu_ex.sv ====
`timescale 1ns/1ps

module cpu_ex import cpu_pkg::*; (
	input  decoded_t decoded,
	output reg_wr_t  result
);

word_t      alu_out;
logic [4:0] sa;

// decode put shamt in opr1, the shifted value in opr2
assign sa = decoded.opr1[4:0];

always_comb begin
	case (decoded.op)
		OP_ADDU, OP_ADDIU:
			alu_out = decoded.opr1 + decoded.opr2;
		OP_SUBU:
			alu_out = decoded.opr1 - decoded.opr2;
		OP_AND, OP_ANDI:
			alu_out = decoded.opr1 & decoded.opr2;
		OP_OR, OP_ORI:
			alu_out = decoded.opr1 | decoded.opr2;
		OP_XOR, OP_XORI:
			alu_out = decoded.opr1 ^ decoded.opr2;
		OP_NOR:
			alu_out = ~(decoded.opr1 | decoded.opr2);
		OP_SLT, OP_SLTI:
			alu_out = {31'b0, $signed(decoded.opr1) < $signed(decoded.opr2)};
		OP_SLTU:
			alu_out = {31'b0, decoded.opr1 < decoded.opr2};
		OP_SLL:
			alu_out = decoded.opr2 << sa;
		OP_SRL:
			alu_out = decoded.opr2 >> sa;
		OP_LUI:
			alu_out = decoded.opr2;
		default:
			alu_out = '0;
	endcase
end

// an unissued slot b keeps its write enable, valid masks it
always_comb begin
	result.we    = decoded.valid && decoded.we;
	result.waddr = decoded.waddr;
	result.wdata = alu_out;
end

endmodule

// ==== verilog/trivial_mips.sv ====
`timescale 1ns/1ps

module trivial_mips import cpu_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  inst_pair_t inst_pair,
	input  logic       inst_valid,
	output logic       inst_ready,
	output commit_t    commit_a,
	output commit_t    commit_b
);

// general registers
reg_addr_t reg_raddr1, reg_raddr2, reg_raddr3, reg_raddr4;
word_t     reg_rdata1, reg_rdata2, reg_rdata3, reg_rdata4;
reg_wr_t   reg_wr1, reg_wr2;

regs general_regs_instance(
	.clk,
	.rst_n,
	.wr1(reg_wr1),
	.wr2(reg_wr2),
	.raddr1(reg_raddr1),
	.raddr2(reg_raddr2),
	.raddr3(reg_raddr3),
	.raddr4(reg_raddr4),
	.rdata1(reg_rdata1),
	.rdata2(reg_rdata2),
	.rdata3(reg_rdata3),
	.rdata4(reg_rdata4)
);

// instruction queue
queue_word_t q_a, q_b;
logic        q_a_valid, q_b_valid;
logic        inst2_taken;

inst_queue inst_queue_instance(
	.clk,
	.rst_n,
	.inst_pair,
	.inst_valid,
	.inst_ready,
	.head_a(q_a),
	.head_b(q_b),
	.head_a_valid(q_a_valid),
	.head_b_valid(q_b_valid),
	.inst2_taken
);

// ID stage
decoded_t data_id_a, data_id_b;
reg_wr_t  ex_wr_a, ex_wr_b;

cpu_id stage_id_a(
	.inst(q_a.inst),
	.pc(q_a.pc),
	.inst_valid(q_a_valid),
	.rdata1(reg_rdata1),
	.rdata2(reg_rdata2),
	.ex_wr_a,
	.ex_wr_b,
	.wb_wr_a(reg_wr1),
	.wb_wr_b(reg_wr2),
	.raddr1(reg_raddr1),
	.raddr2(reg_raddr2),
	.decoded(data_id_a)
);

cpu_id stage_id_b(
	.inst(q_b.inst),
	.pc(q_b.pc),
	.inst_valid(q_b_valid),
	.rdata1(reg_rdata3),
	.rdata2(reg_rdata4),
	.ex_wr_a,
	.ex_wr_b,
	.wb_wr_a(reg_wr1),
	.wb_wr_b(reg_wr2),
	.raddr1(reg_raddr3),
	.raddr2(reg_raddr4),
	.decoded(data_id_b)
);

superscalar_ctrl superscalar_ctrl_instance(
	.decoded_a(data_id_a),
	.decoded_b(data_id_b),
	.inst2_taken
);

decoded_pair_t idex_in, idex_out;

always_comb begin
	idex_in[0] = data_id_a;
	idex_in[1] = data_id_b;
	// b stays in the queue unless paired
	idex_in[1].valid = data_id_b.valid & inst2_taken;
end

pipe_reg #(.payload_t(decoded_pair_t)) stage_id_ex(
	.clk,
	.rst_n,
	.in_data(idex_in),
	.out_data(idex_out)
);

// EX stage
cpu_ex stage_ex_a(
	.decoded(idex_out[0]),
	.result(ex_wr_a)
);

cpu_ex stage_ex_b(
	.decoded(idex_out[1]),
	.result(ex_wr_b)
);

commit_pair_t exwb_in, exwb_out;
assign exwb_in[0] = to_commit(ex_wr_a, idex_out[0].pc);
assign exwb_in[1] = to_commit(ex_wr_b, idex_out[1].pc);

pipe_reg #(.payload_t(commit_pair_t)) stage_ex_wb(
	.clk,
	.rst_n,
	.in_data(exwb_in),
	.out_data(exwb_out)
);

// WB stage
assign reg_wr1  = commit_to_wr(exwb_out[0]);
assign reg_wr2  = commit_to_wr(exwb_out[1]);
assign commit_a = exwb_out[0];
assign commit_b = exwb_out[1];

endmodule

// ==== verification/tb_trivial_mips.sv ====
`timescale 1ns/1ps

module tb_trivial_mips import cpu_pkg::*; ();

localparam int WAIT_LIMIT  = 50;
localparam int DRAIN_LIMIT = 100;
localparam int RAND_PAIRS  = 64;
localparam reg_addr_t NO_DEST = 5'd0;

typedef struct packed {
	word_t     inst1;
	reg_addr_t dest1;
	word_t     data1;
	word_t     inst2;
	reg_addr_t dest2;
	word_t     data2;
} dir_row_t;

logic       clk = 1'b0;
logic       rst_n;
inst_pair_t inst_pair;
logic       inst_valid;
logic       inst_ready;
commit_t    commit_a, commit_b;

dir_row_t dir_tab [$];
commit_t  exp_q [$];
word_t    prog [$];
word_t    model_rf [32];
word_t    lcg_state;
word_t    next_pc;
int       sent_count;
int       commit_count;
int       stall_cycles;

trivial_mips DUT (
	.clk,
	.rst_n,
	.inst_pair,
	.inst_valid,
	.inst_ready,
	.commit_a,
	.commit_b
);

always #50 clk = ~clk;

task automatic stop_run(string why);
	$display("%s", why);
	$display("sim failed");
	$fatal(1);
endtask

task automatic check_commit(string name, commit_t got, commit_t exp);
	string msg;
	if (got !== exp) begin
		msg = $sformatf("error: %s got valid=%h pc=%h waddr=%h wdata=%h", name,
			got.valid, got.pc, got.waddr, got.wdata);
		msg = {msg, $sformatf(" expected valid=%h pc=%h waddr=%h wdata=%h",
			exp.valid, exp.pc, exp.waddr, exp.wdata)};
		stop_run(msg);
	end
endtask

task automatic check_word(string name, word_t got, word_t exp);
	if (got !== exp)
		stop_run($sformatf("error: %s got %h expected %h", name, got, exp));
endtask

function automatic word_t r_op(logic [5:0] fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
	return {6'h00, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t sh_op(logic [5:0] fn, reg_addr_t rd, reg_addr_t rt, logic [4:0] sa);
	return {6'h00, 5'd0, rt, rd, sa, fn};
endfunction

function automatic word_t i_op(logic [5:0] opc, reg_addr_t rt, reg_addr_t rs,
		logic [15:0] imm);
	return {opc, rs, rt, imm};
endfunction

function automatic word_t lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state;
endfunction

// registers r0 to r7 only so dependences and r0 bubbles show up often
function automatic word_t random_inst();
	word_t r, s;
	reg_addr_t rs, rt, rd;
	r  = lcg_next();
	s  = lcg_next();
	rs = {2'b0, s[31:29]};
	rt = {2'b0, s[28:26]};
	rd = {2'b0, s[25:23]};
	case (r[31:28])
		4'd0:  return r_op(6'h21, rd, rs, rt);
		4'd1:  return r_op(6'h23, rd, rs, rt);
		4'd2:  return r_op(6'h24, rd, rs, rt);
		4'd3:  return r_op(6'h25, rd, rs, rt);
		4'd4:  return r_op(6'h26, rd, rs, rt);
		4'd5:  return r_op(6'h27, rd, rs, rt);
		4'd6:  return r_op(6'h2a, rd, rs, rt);
		4'd7:  return r_op(6'h2b, rd, rs, rt);
		4'd8:  return sh_op(6'h00, rd, rt, s[22:18]);
		4'd9:  return sh_op(6'h02, rd, rt, s[22:18]);
		4'd10: return i_op(6'h09, rt, rs, s[17:2]);
		4'd11: return i_op(6'h0a, rt, rs, s[17:2]);
		4'd12: return i_op(6'h0c, rt, rs, s[17:2]);
		4'd13: return i_op(6'h0d, rt, rs, s[17:2]);
		4'd14: return i_op(6'h0e, rt, rs, s[17:2]);
		default: return i_op(6'h0f, rt, rs, s[17:2]);
	endcase
endfunction

// program-order register model that returns NO_DEST for a bubble
task automatic model_step(input word_t inst, output reg_addr_t dest, output word_t data);
	logic [5:0] opc, fn;
	word_t a, b, sext, zext;
	logic known;
	opc   = inst[31:26];
	fn    = inst[5:0];
	a     = model_rf[inst[25:21]];
	b     = model_rf[inst[20:16]];
	sext  = {{16{inst[15]}}, inst[15:0]};
	zext  = {16'h0, inst[15:0]};
	known = 1'b1;
	dest  = inst[20:16];
	data  = '0;
	case (opc)
		6'h00: begin
			dest = inst[15:11];
			case (fn)
				6'h21: data = a + b;
				6'h23: data = a - b;
				6'h24: data = a & b;
				6'h25: data = a | b;
				6'h26: data = a ^ b;
				6'h27: data = ~(a | b);
				6'h2a: data = {31'b0, $signed(a) < $signed(b)};
				6'h2b: data = {31'b0, a < b};
				6'h00: data = b << inst[10:6];
				6'h02: data = b >> inst[10:6];
				default: known = 1'b0;
			endcase
		end
		6'h09: data = a + sext;
		6'h0a: data = {31'b0, $signed(a) < $signed(sext)};
		6'h0c: data = a & zext;
		6'h0d: data = a | zext;
		6'h0e: data = a ^ zext;
		6'h0f: data = {inst[15:0], 16'h0};
		default: known = 1'b0;
	endcase
	if (!known || dest == NO_DEST)
		dest = NO_DEST;
	else
		model_rf[dest] = data;
endtask

function automatic logic reads_reg(word_t inst, reg_addr_t r);
	logic [5:0] opc, fn;
	opc = inst[31:26];
	fn  = inst[5:0];
	if (opc == 6'h00) begin
		if (fn == 6'h00 || fn == 6'h02)
			return inst[20:16] == r;
		return inst[25:21] == r || inst[20:16] == r;
	end
	if (opc == 6'h0f)
		return 1'b0;
	return inst[25:21] == r;
endfunction

task automatic add_row(word_t i1, reg_addr_t d1, word_t v1, word_t i2, reg_addr_t d2,
		word_t v2);
	dir_row_t row;
	row.inst1 = i1;
	row.dest1 = d1;
	row.data1 = v1;
	row.inst2 = i2;
	row.dest2 = d2;
	row.data2 = v2;
	dir_tab.push_back(row);
endtask

// registers start at zero and values follow in program order
task automatic build_table();
	add_row(i_op(6'h0f, 5'd1, 5'd0, 16'h1234), 5'd1, 32'h12340000,
		i_op(6'h0d, 5'd2, 5'd0, 16'h5678), 5'd2, 32'h00005678);
	add_row(i_op(6'h0d, 5'd1, 5'd1, 16'habcd), 5'd1, 32'h1234abcd,
		r_op(6'h21, 5'd3, 5'd1, 5'd2), 5'd3, 32'h12350245);
	add_row(r_op(6'h23, 5'd4, 5'd3, 5'd2), 5'd4, 32'h1234abcd,
		r_op(6'h24, 5'd5, 5'd3, 5'd1), 5'd5, 32'h12340245);
	add_row(r_op(6'h25, 5'd6, 5'd4, 5'd5), 5'd6, 32'h1234abcd,
		r_op(6'h26, 5'd7, 5'd6, 5'd3), 5'd7, 32'h0001a988);
	add_row(r_op(6'h27, 5'd8, 5'd7, 5'd0), 5'd8, 32'hfffe5677,
		r_op(6'h2a, 5'd9, 5'd8, 5'd2), 5'd9, 32'h00000001);
	add_row(r_op(6'h2b, 5'd10, 5'd8, 5'd2), 5'd10, 32'h00000000,
		sh_op(6'h00, 5'd11, 5'd2, 5'd4), 5'd11, 32'h00056780);
	add_row(sh_op(6'h02, 5'd12, 5'd11, 5'd8), 5'd12, 32'h00000567,
		i_op(6'h09, 5'd13, 5'd12, 16'hffff), 5'd13, 32'h00000566);
	add_row(i_op(6'h0c, 5'd14, 5'd8, 16'hff00), 5'd14, 32'h00005600,
		i_op(6'h0e, 5'd15, 5'd8, 16'h8001), 5'd15, 32'hfffed676);
	add_row(i_op(6'h0a, 5'd16, 5'd8, 16'hfffe), 5'd16, 32'h00000001,
		i_op(6'h0a, 5'd17, 5'd2, 16'h7fff), 5'd17, 32'h00000001);
	add_row(r_op(6'h21, 5'd0, 5'd1, 5'd2), NO_DEST, 32'h0,
		32'hfc000000, NO_DEST, 32'h0);
	add_row(32'h8c220000, NO_DEST, 32'h0,
		r_op(6'h21, 5'd18, 5'd13, 5'd12), 5'd18, 32'h00000acd);
	add_row(i_op(6'h09, 5'd1, 5'd1, 16'h0001), 5'd1, 32'h1234abce,
		i_op(6'h09, 5'd1, 5'd1, 16'h0002), 5'd1, 32'h1234abd0);
	add_row(r_op(6'h21, 5'd19, 5'd1, 5'd0), 5'd19, 32'h1234abd0,
		i_op(6'h0d, 5'd1, 5'd0, 16'h0055), 5'd1, 32'h00000055);
	add_row(r_op(6'h23, 5'd20, 5'd0, 5'd1), 5'd20, 32'hffffffab,
		i_op(6'h0f, 5'd21, 5'd0, 16'hffff), 5'd21, 32'hffff0000);
endtask

task automatic expect_commit(word_t pc, reg_addr_t dest, word_t data);
	commit_t e;
	if (dest != NO_DEST) begin
		e.valid = 1'b1;
		e.pc    = pc;
		e.waddr = dest;
		e.wdata = data;
		exp_q.push_back(e);
		sent_count++;
	end
endtask

// entered and left 5 ns after a rising edge and holds the pair until accepted
task automatic send_pair(word_t i1, word_t i2, int gap);
	int   g;
	int   waited;
	logic accepted;
	for (g = 0; g < gap; g++) begin
		inst_valid = 1'b0;
		@(posedge clk);
		#5;
	end
	prog.push_back(i1);
	prog.push_back(i2);
	inst_pair.pc    = next_pc;
	inst_pair.inst1 = i1;
	inst_pair.inst2 = i2;
	inst_valid      = 1'b1;
	accepted = 1'b0;
	waited   = 0;
	while (!accepted) begin
		@(negedge clk);
		accepted = inst_ready;
		if (!accepted) begin
			stall_cycles++;
			waited++;
			if (waited > WAIT_LIMIT)
				stop_run("timeout: inst_ready stayed low while a pair was held");
		end
		@(posedge clk);
		#5;
	end
	inst_valid = 1'b0;
	next_pc    = next_pc + 32'd8;
endtask

task automatic take_commit(string name, commit_t c);
	commit_t e;
	if (c.waddr == NO_DEST)
		stop_run($sformatf("%s wrote r0 at pc %h", name, c.pc));
	if (exp_q.size() == 0)
		stop_run($sformatf("%s committed pc %h with nothing outstanding", name, c.pc));
	e = exp_q.pop_front();
	check_commit(name, c, e);
	commit_count++;
endtask

task automatic check_pairing();
	int idx;
	check_word("commit_b.pc", commit_b.pc, commit_a.pc + 32'd4);
	idx = int'(commit_b.pc >> 2);
	if (idx >= prog.size())
		stop_run($sformatf("commit_b pc %h was never sent", commit_b.pc));
	if (reads_reg(prog[idx], commit_a.waddr))
		stop_run($sformatf("pc %h issued with pc %h but reads its destination r%0d",
			commit_b.pc, commit_a.pc, commit_a.waddr));
endtask

// outputs settle well before the falling edge
always @(negedge clk) begin
	if (rst_n) begin
		if (commit_a.valid && commit_b.valid)
			check_pairing();
		if (commit_a.valid)
			take_commit("commit_a", commit_a);
		if (commit_b.valid)
			take_commit("commit_b", commit_b);
	end
end

initial begin
	word_t     pc, i1, i2, v1, v2, r;
	reg_addr_t d1, d2;
	int        waited;
	rst_n        = 1'b0;
	inst_valid   = 1'b0;
	inst_pair    = '0;
	lcg_state    = 32'd6968;
	next_pc      = '0;
	sent_count   = 0;
	commit_count = 0;
	stall_cycles = 0;
	for (int i = 0; i < 32; i++)
		model_rf[i] = '0;
	repeat (3) @(posedge clk);
	#5;
	rst_n = 1'b1;

	@(negedge clk);
	check_commit("commit_a", commit_a, '0);
	check_commit("commit_b", commit_b, '0);
	check_word("inst_ready", {31'b0, inst_ready}, 32'd1);
	@(posedge clk);
	#5;

	// directed pairs back to back
	build_table();
	foreach (dir_tab[i]) begin
		pc = next_pc;
		model_step(dir_tab[i].inst1, d1, v1);
		model_step(dir_tab[i].inst2, d2, v2);
		send_pair(dir_tab[i].inst1, dir_tab[i].inst2, 0);
		expect_commit(pc, dir_tab[i].dest1, dir_tab[i].data1);
		expect_commit(pc + 32'd4, dir_tab[i].dest2, dir_tab[i].data2);
	end

	// random pairs with occasional gaps in inst_valid
	for (int n = 0; n < RAND_PAIRS; n++) begin
		pc = next_pc;
		i1 = random_inst();
		i2 = random_inst();
		r  = lcg_next();
		model_step(i1, d1, v1);
		model_step(i2, d2, v2);
		send_pair(i1, i2, (r[31:30] == 2'b11) ? int'(r[29:28]) : 0);
		expect_commit(pc, d1, v1);
		expect_commit(pc + 32'd4, d2, v2);
	end

	waited = 0;
	while (commit_count != sent_count) begin
		@(posedge clk);
		waited++;
		if (waited > DRAIN_LIMIT)
			stop_run($sformatf("timeout: %0d of %0d commits seen after the stream drained",
				commit_count, sent_count));
	end
	// a few more cycles to catch stray commits
	repeat (4) @(posedge clk);
	if (stall_cycles == 0)
		stop_run("inst_ready never went low while pairs were streaming");

	$display("sim passed");
	$finish;
end

endmodule

// ==== build.f ====
verilog/cpu_pkg.sv
verilog/pipe_reg.sv
verilog/inst_queue.sv
verilog/regs.sv
verilog/cpu_id.sv
verilog/superscalar_ctrl.sv
verilog/cpu_ex.sv
verilog/trivial_mips.sv
verification/tb_trivial_mips.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_trivial_mips
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
